// ==== rtl/cpu_config.svh ====
// widths and vectors assume a 32-bit word; both memories must stay a power of two deep
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// datapath and register file
`define WORD_W      32
`define REG_ADDR_W  5

// memory depths in words
`define IMEM_WORDS  256
`define DMEM_WORDS  256

// fetch addresses after reset and on an illegal instruction
`define RESET_VECTOR 32'h8000_0000
`define EXC_VECTOR   32'h8000_0008

// fixed destinations for return addresses
`define EXC_REG     26  // exception return address
`define LINK_REG    31  // jal / jalr link

// store address bit that selects the peripheral port
`define PER_BIT     30

`endif

// ==== rtl/cpuPkg.sv ====
// types and encodings for the MIPS-like subset; ALU codes are group in [5:4], op below
`default_nettype none

package cpuPkg;
    `include "cpu_config.svh"

    typedef logic [`WORD_W-1:0]     wordT;
    typedef logic [`REG_ADDR_W-1:0] regAddrT;
    typedef logic [5:0]             aluFunT;
    typedef logic [2:0]             pcSrcT;
    typedef logic [1:0]             regDstT;
    typedef logic [1:0]             memToRegT;

    // opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00, OP_J = 6'h02, OP_JAL = 6'h03;
    localparam logic [5:0] OP_BEQ = 6'h04, OP_BNE = 6'h05;
    localparam logic [5:0] OP_ADDI = 6'h08, OP_ADDIU = 6'h09, OP_SLTI = 6'h0a;
    localparam logic [5:0] OP_SLTIU = 6'h0b, OP_ANDI = 6'h0c, OP_ORI = 6'h0d;
    localparam logic [5:0] OP_LUI = 6'h0f, OP_LW = 6'h23, OP_SW = 6'h2b;

    // funct field of R-type
    localparam logic [5:0] FN_SLL = 6'h00, FN_SRL = 6'h02, FN_SRA = 6'h03;
    localparam logic [5:0] FN_JR = 6'h08, FN_JALR = 6'h09;
    localparam logic [5:0] FN_ADD = 6'h20, FN_ADDU = 6'h21, FN_SUB = 6'h22;
    localparam logic [5:0] FN_SUBU = 6'h23, FN_AND = 6'h24, FN_OR = 6'h25;
    localparam logic [5:0] FN_XOR = 6'h26, FN_NOR = 6'h27;
    localparam logic [5:0] FN_SLT = 6'h2a, FN_SLTU = 6'h2b;

    // ALU groups, fun[5:4]
    localparam logic [1:0] GRP_ARITH = 2'b00, GRP_LOGIC = 2'b01;
    localparam logic [1:0] GRP_SHIFT = 2'b10, GRP_CMP = 2'b11;

    // ALU codes; logic ops carry their truth table in [3:0], index {a,b}
    localparam aluFunT ALU_ADD = 6'b000000, ALU_SUB = 6'b000001;
    localparam aluFunT ALU_AND = 6'b011000, ALU_OR = 6'b011110;
    localparam aluFunT ALU_XOR = 6'b010110, ALU_NOR = 6'b010001;
    localparam aluFunT ALU_PASSB = 6'b011010;
    localparam aluFunT ALU_SLL = 6'b100000, ALU_SRL = 6'b100001, ALU_SRA = 6'b100011;
    localparam aluFunT ALU_EQ = 6'b110011, ALU_NEQ = 6'b110001, ALU_LT = 6'b110101;

    // next-PC select
    localparam pcSrcT PC_SEQ = 3'd0, PC_BRANCH = 3'd1, PC_JUMP = 3'd2;
    localparam pcSrcT PC_REG = 3'd3, PC_EXC = 3'd4;

    // write-register select
    localparam regDstT RD_RT = 2'd0, RD_RD = 2'd1, RD_LINK = 2'd2, RD_EXC = 2'd3;

    // writeback select
    localparam memToRegT WB_ALU = 2'd0, WB_MEM = 2'd1, WB_PC4 = 2'd2;
endpackage

`default_nettype wire

// ==== rtl/instrMem.sv ====
// loaded only while the CPU is held in reset; pc bit 31 and bits above the index are ignored
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module instrMem (
    input  logic         clk,
    input  logic         progWrite,
    input  cpuPkg::wordT progAddr,
    input  cpuPkg::wordT progData,
    input  cpuPkg::wordT pc,
    output cpuPkg::wordT instr
);
    localparam int AW = $clog2(`IMEM_WORDS);

    logic [`WORD_W-1:0] mem [`IMEM_WORDS];

    // unloaded words decode as sll r0, a no-op
    initial begin
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (progWrite) begin
            mem[progAddr[AW+1:2]] <= progData;
        end
    end

    assign instr = mem[pc[AW+1:2]];  // word index, kernel bit dropped

endmodule

`default_nettype wire

// ==== rtl/control.sv ====
// purely combinational decode; anything outside the subset traps to the exception vector
`timescale 1ns/1ps
`default_nettype none

module control (
    input  logic              [5:0] opcode,
    input  logic              [5:0] funct,
    output cpuPkg::pcSrcT           pcSrc,
    output cpuPkg::regDstT          regDst,
    output logic                    regWrite,
    output logic                    aluSrcA,
    output logic                    aluSrcB,
    output cpuPkg::aluFunT          aluFun,
    output logic                    signedCmp,
    output logic                    memWrite,
    output cpuPkg::memToRegT        memToReg,
    output logic                    signExt,
    output logic                    loadUpper
);
    import cpuPkg::*;

    logic illegal;

    always_comb begin
        // defaults describe an R-type ALU op without writeback
        pcSrc     = PC_SEQ;
        regDst    = RD_RD;
        regWrite  = 1'b0;
        aluSrcA   = 1'b0;
        aluSrcB   = 1'b0;
        aluFun    = ALU_ADD;
        signedCmp = 1'b1;
        memWrite  = 1'b0;
        memToReg  = WB_ALU;
        signExt   = 1'b1;
        loadUpper = 1'b0;
        illegal   = 1'b0;

        case (opcode)
            OP_RTYPE: begin
                regWrite = 1'b1;
                case (funct)
                    FN_ADD, FN_ADDU: aluFun = ALU_ADD;
                    FN_SUB, FN_SUBU: aluFun = ALU_SUB;
                    FN_AND:          aluFun = ALU_AND;
                    FN_OR:           aluFun = ALU_OR;
                    FN_XOR:          aluFun = ALU_XOR;
                    FN_NOR:          aluFun = ALU_NOR;
                    FN_SLT:          aluFun = ALU_LT;
                    FN_SLTU: begin
                        aluFun    = ALU_LT;
                        signedCmp = 1'b0;
                    end
                    FN_SLL, FN_SRL, FN_SRA: begin
                        aluSrcA = 1'b1;                  // shamt field
                        aluFun  = {GRP_SHIFT, 2'b00, funct[1:0]};
                    end
                    FN_JR: begin
                        pcSrc    = PC_REG;
                        regWrite = 1'b0;
                    end
                    FN_JALR: begin
                        pcSrc    = PC_REG;
                        regDst   = RD_LINK;
                        memToReg = WB_PC4;
                    end
                    default: illegal = 1'b1;
                endcase
            end
            OP_ADDI, OP_ADDIU: begin
                regDst   = RD_RT;
                regWrite = 1'b1;
                aluSrcB  = 1'b1;
            end
            OP_SLTI, OP_SLTIU: begin
                regDst    = RD_RT;
                regWrite  = 1'b1;
                aluSrcB   = 1'b1;
                aluFun    = ALU_LT;
                signedCmp = (opcode == OP_SLTI);       // imm still sign-extended
            end
            OP_ANDI, OP_ORI: begin
                regDst   = RD_RT;
                regWrite = 1'b1;
                aluSrcB  = 1'b1;
                signExt  = 1'b0;
                aluFun   = (opcode == OP_ANDI) ? ALU_AND : ALU_OR;
            end
            OP_LUI: begin
                regDst    = RD_RT;
                regWrite  = 1'b1;
                aluSrcB   = 1'b1;
                loadUpper = 1'b1;
                aluFun    = ALU_PASSB;
            end
            OP_LW: begin
                regDst   = RD_RT;
                regWrite = 1'b1;
                aluSrcB  = 1'b1;
                memToReg = WB_MEM;
            end
            OP_SW: begin
                aluSrcB  = 1'b1;
                memWrite = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                pcSrc  = PC_BRANCH;                    // taken on ALU bit 0
                aluFun = (opcode == OP_BEQ) ? ALU_EQ : ALU_NEQ;
            end
            OP_J:    pcSrc = PC_JUMP;
            OP_JAL: begin
                pcSrc    = PC_JUMP;
                regDst   = RD_LINK;
                regWrite = 1'b1;
                memToReg = WB_PC4;
            end
            default: illegal = 1'b1;
        endcase

        if (illegal) begin
            pcSrc    = PC_EXC;
            regDst   = RD_EXC;
            regWrite = 1'b1;   // r26 gets return address
            memToReg = WB_PC4;
            memWrite = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/regFile.sv ====
// register zero is never stored and always reads 0; reads are combinational
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic            clk,
    input  logic            reset,
    input  cpuPkg::regAddrT addrA,
    input  cpuPkg::regAddrT addrB,
    input  cpuPkg::regAddrT addrW,
    input  logic            writeEn,
    input  cpuPkg::wordT    dataW,
    output cpuPkg::wordT    dataA,
    output cpuPkg::wordT    dataB
);
    localparam int REGS = 2 ** $bits(addrW);

    cpuPkg::wordT regs [1:REGS-1];  // no storage for r0

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 1; i < REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && addrW != '0) begin
            regs[addrW] <= dataW;
        end
    end

    // new value visible only after the edge
    assign dataA = (addrA == '0) ? '0 : regs[addrA];
    assign dataB = (addrB == '0) ? '0 : regs[addrB];

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
// one adder serves add, sub and the compares; no overflow detection
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  cpuPkg::wordT   a,
    input  cpuPkg::wordT   b,
    input  cpuPkg::aluFunT fun,
    input  logic           signedCmp,
    output cpuPkg::wordT   result
);
    import cpuPkg::*;

    localparam int W = $bits(wordT);

    logic         sub;
    logic [W:0]   sum;       // carry out in the top bit
    wordT         logicRes;
    wordT         shiftRes;
    logic [$clog2(W)-1:0] shamt;
    logic         lessThan;
    logic         equal;
    logic         cmpBit;

    assign sub = fun[0];     // every compare code is odd, so it subtracts too
    assign sum = {1'b0, a} + {1'b0, b ^ {W{sub}}} + {{W{1'b0}}, sub};

    // no carry out of a - b means a borrow
    assign lessThan = signedCmp ? ((a[W-1] != b[W-1]) ? a[W-1] : sum[W-1])
                                : ~sum[W];
    assign equal    = (a == b);

    always_comb begin
        for (int i = 0; i < W; i++) begin
            logicRes[i] = fun[{a[i], b[i]}];  // truth table lookup
        end
    end

    assign shamt = a[$clog2(W)-1:0];

    always_comb begin
        case (fun[1:0])
            2'b00:   shiftRes = b << shamt;
            2'b11:   shiftRes = wordT'($signed(b) >>> shamt);
            default: shiftRes = b >> shamt;
        endcase
    end

    always_comb begin
        case (fun[3:1])
            3'b001:  cmpBit = equal;
            3'b000:  cmpBit = ~equal;
            3'b010:  cmpBit = lessThan;
            default: cmpBit = 1'b0;
        endcase
    end

    always_comb begin
        case (fun[5:4])
            GRP_ARITH: result = sum[W-1:0];
            GRP_LOGIC: result = logicRes;
            GRP_SHIFT: result = shiftRes;
            default:   result = {{(W-1){1'b0}}, cmpBit};  // bit 0 drives branches
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/dataMem.sv ====
// word access only; no reset, so contents are undefined until written
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module dataMem (
    input  logic         clk,
    input  logic         writeEn,
    input  cpuPkg::wordT addr,
    input  cpuPkg::wordT wdata,
    output cpuPkg::wordT rdata
);
    localparam int AW = $clog2(`DMEM_WORDS);

    logic [AW-1:0] index;
    cpuPkg::wordT  mem [`DMEM_WORDS];

    assign index = addr[AW+1:2];  // byte offset dropped

    always_ff @(posedge clk) begin
        if (writeEn) begin
            mem[index] <= wdata;
        end
    end

    // read during the same cycle
    assign rdata = mem[index];

endmodule

`default_nettype wire

// ==== rtl/monoCpu.sv ====
// one instruction per clock; no interrupts, no delay slots, peripheral region is write-only
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module monoCpu (
    input  logic         clk,
    input  logic         reset,
    input  logic         progWrite,
    input  cpuPkg::wordT progAddr,
    input  cpuPkg::wordT progData,
    output logic         perWrite,
    output cpuPkg::wordT perAddr,
    output cpuPkg::wordT perData
);
    import cpuPkg::*;

    localparam int   W       = $bits(wordT);
    localparam wordT EXC_VEC = `EXC_VECTOR;

    wordT       pc, pcNext, pcPlus4;
    wordT       branchTarget, jumpTarget, excTarget;
    wordT       instr;
    logic [5:0] opcode, funct;
    regAddrT    rs, rt, rd, regW;
    logic [4:0] shamt;
    logic [15:0] imm16;
    logic [25:0] jumpField;

    pcSrcT      pcSrc;
    regDstT     regDst;
    memToRegT   memToReg;
    aluFunT     aluFun;
    logic       regWrite, aluSrcA, aluSrcB, signedCmp;
    logic       memWrite, signExt, loadUpper;

    wordT       dataA, dataB, dataW;
    wordT       immSext, extImm;
    wordT       aluA, aluB, aluResult, memData;
    logic       storeEn, perSel;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc <= `RESET_VECTOR;
        end else begin
            pc <= pcNext;
        end
    end

    instrMem imem0 (
        .clk(clk), .progWrite(progWrite), .progAddr(progAddr),
        .progData(progData), .pc(pc), .instr(instr)
    );

    assign opcode    = instr[31:26];
    assign rs        = instr[25:21];
    assign rt        = instr[20:16];
    assign rd        = instr[15:11];
    assign shamt     = instr[10:6];
    assign funct     = instr[5:0];
    assign imm16     = instr[15:0];
    assign jumpField = instr[25:0];

    control ctrl0 (
        .opcode(opcode), .funct(funct), .pcSrc(pcSrc), .regDst(regDst),
        .regWrite(regWrite), .aluSrcA(aluSrcA), .aluSrcB(aluSrcB),
        .aluFun(aluFun), .signedCmp(signedCmp), .memWrite(memWrite),
        .memToReg(memToReg), .signExt(signExt), .loadUpper(loadUpper)
    );

    always_comb begin
        case (regDst)
            RD_RT:   regW = rt;
            RD_RD:   regW = rd;
            RD_LINK: regW = regAddrT'(`LINK_REG);
            default: regW = regAddrT'(`EXC_REG);
        endcase
    end

    regFile rf0 (
        .clk(clk), .reset(reset), .addrA(rs), .addrB(rt), .addrW(regW),
        .writeEn(regWrite), .dataW(dataW), .dataA(dataA), .dataB(dataB)
    );

    // immediate forms
    assign immSext = {{(W-16){imm16[15]}}, imm16};
    assign extImm  = loadUpper ? {imm16, {(W-16){1'b0}}}
                   : signExt   ? immSext
                   :             {{(W-16){1'b0}}, imm16};

    assign aluA = aluSrcA ? {{(W-5){1'b0}}, shamt} : dataA;
    assign aluB = aluSrcB ? extImm : dataB;

    alu alu0 (
        .a(aluA), .b(aluB), .fun(aluFun), .signedCmp(signedCmp), .result(aluResult)
    );

    // stores split on the peripheral bit, none while held in reset
    assign perSel   = aluResult[`PER_BIT];
    assign storeEn  = memWrite & reset;
    assign perWrite = storeEn & perSel;
    assign perAddr  = aluResult;
    assign perData  = dataB;

    dataMem dmem0 (
        .clk(clk), .writeEn(storeEn & ~perSel), .addr(aluResult),
        .wdata(dataB), .rdata(memData)
    );

    always_comb begin
        case (memToReg)
            WB_ALU:  dataW = aluResult;
            WB_MEM:  dataW = memData;
            default: dataW = pcPlus4;  // link / exception return
        endcase
    end

    // bit 31 carried over from the current pc
    assign pcPlus4      = {pc[W-1], pc[W-2:0] + (W-1)'(4)};
    assign branchTarget = {pc[W-1], pcPlus4[W-2:0] + {immSext[W-4:0], 2'b00}};
    assign jumpTarget   = {pcPlus4[W-1:W-4], jumpField, 2'b00};
    assign excTarget    = {pc[W-1], EXC_VEC[W-2:0]};

    always_comb begin
        case (pcSrc)
            PC_BRANCH: pcNext = aluResult[0] ? branchTarget : pcPlus4;
            PC_JUMP:   pcNext = jumpTarget;
            PC_REG:    pcNext = dataA;     // jr / jalr, taken as is
            PC_EXC:    pcNext = excTarget;
            default:   pcNext = pcPlus4;
        endcase
    end

endmodule

`default_nettype wire

// ==== test/monoCpu_sva.sv ====
// sampled on rising edges; the register file read port is watched through the top-level nets feeding it
`timescale 1ns/1ps
`default_nettype none

module monoCpuSva (
    input logic            clk,
    input logic            reset,
    input logic            perWrite,
    input cpuPkg::wordT    pc,
    input cpuPkg::regAddrT addrA,
    input cpuPkg::wordT    dataA
);

    perKnown: assert property (@(posedge clk) !$isunknown(perWrite))
        else $error("perWrite is unknown");

    // no stores leak out while the program is loaded
    perQuietInReset: assert property (@(posedge clk) !reset |-> !perWrite)
        else $error("peripheral write while reset is asserted");

    zeroReg: assert property (@(posedge clk) disable iff (!reset)
        (addrA == '0) |-> (dataA == '0))
        else $error("register zero read back nonzero");

    pcAligned: assert property (@(posedge clk) disable iff (!reset) pc[1:0] == 2'b00)
        else $error("pc is not word aligned");

endmodule

bind monoCpu monoCpuSva sva0 (
    .clk(clk), .reset(reset), .perWrite(perWrite), .pc(pc), .addrA(rs), .dataA(dataA)
);

`default_nettype wire

// ==== test/monoCpuTb.sv ====
// programs start at the reset vector with a trap handler at word 2; the marker store ends each test
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module monoCpuTb;
    import cpuPkg::*;

    localparam wordT PER_BASE    = 32'h4000_0000;
    localparam int   MARK_OFF    = 'h0ff0;  // marker store ends a test
    localparam int   BAD_OFF     = 'h0700;  // only reached on a wrong path
    localparam int   RUN_LIMIT   = 256;
    localparam int   TEST_CYCLES = RUN_LIMIT + 8 + `IMEM_WORDS;

    logic clk;
    logic reset;
    logic progWrite;
    logic perWrite;
    wordT progAddr;
    wordT progData;
    wordT perAddr;
    wordT perData;
    wordT prog[$];
    wordT expAddr[$];
    wordT expData[$];
    wordT gotAddr[$];
    wordT gotData[$];
    int   errorCount = 0;
    int   passCount = 0;
    int   failCount = 0;
    int   outOff;
    int   seed = 15;

    monoCpu dut0 (
        .clk(clk), .reset(reset), .progWrite(progWrite), .progAddr(progAddr),
        .progData(progData), .perWrite(perWrite), .perAddr(perAddr), .perData(perData)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // six tests at their longest, plus a little slack
    initial begin
        #((6 * TEST_CYCLES + 16) * 4);
        $display("watchdog expired, the run did not finish in time");
        $display("SIMULATION FAILED");
        $finish;
    end

    function automatic wordT rInstr(logic [5:0] fn, int rd, int rs, int rt, int sh);
        return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic wordT iInstr(logic [5:0] op, int rt, int rs, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    // field equals the word index since programs sit at the reset vector
    function automatic wordT jInstr(logic [5:0] op, int index);
        return {op, 26'(index)};
    endfunction

    function automatic wordT addrOf(int index);
        return `RESET_VECTOR + 32'(index) * 4;
    endfunction

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic emit(wordT w);
        prog.push_back(w);
    endtask

    task automatic expectWrite(wordT addr, wordT data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    task automatic loadConst(int r, wordT v);
        emit(iInstr(OP_LUI, r, 0, int'(v[31:16])));
        emit(iInstr(OP_ORI, r, r, int'(v[15:0])));
    endtask

    task automatic storeOut(int r, wordT v);
        emit(iInstr(OP_SW, r, 27, outOff));
        expectWrite(PER_BASE + outOff, v);
        outOff += 4;
    endtask

    task automatic badStore();
        emit(iInstr(OP_SW, 0, 27, BAD_OFF));
    endtask

    task automatic endProgram();
        emit(iInstr(OP_SW, 0, 27, MARK_OFF));
    endtask

    task automatic startProgram();
        prog.delete();
        expAddr.delete();
        expData.delete();
        outOff = 0;
        emit(jInstr(OP_J, 8));                  // over the handler
        emit(0);
        emit(iInstr(OP_LUI, 27, 0, 'h4000));    // handler at EXC_VECTOR
        emit(iInstr(OP_SW, 26, 27, 'h800));
        endProgram();
        while (prog.size() < 8) begin
            emit(0);
        end
        emit(iInstr(OP_LUI, 27, 0, 'h4000));    // r27 = peripheral base
    endtask

    task automatic checkValue(string what, wordT expected, wordT actual);
        if (expected !== actual) begin
            $display("mismatch in %s: expected %h, actual %h", what, expected, actual);
            errorCount++;
        end
    endtask

    task automatic runProgram(string name);
        int  cycles;
        int  errorsBefore;
        bit  done;
        errorsBefore = errorCount;
        gotAddr.delete();
        gotData.delete();
        nextCycle();
        reset = 1'b0;
        repeat (8) nextCycle();
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            progWrite = 1'b1;
            progAddr  = addrOf(i);
            progData  = (i < prog.size()) ? prog[i] : '0;  // clears leftovers
            nextCycle();
        end
        progWrite = 1'b0;
        reset     = 1'b1;
        done      = 1'b0;
        cycles    = 0;
        while (!done && cycles < RUN_LIMIT) begin
            @(negedge clk);  // port holds until the store's closing edge
            if (perWrite && perAddr == PER_BASE + MARK_OFF) begin
                done = 1'b1;
            end else if (perWrite) begin
                gotAddr.push_back(perAddr);
                gotData.push_back(perData);
            end
            cycles++;
        end
        if (!done) begin
            $display("test %s: program did not reach its marker store within %0d cycles",
                     name, RUN_LIMIT);
            errorCount++;
        end else if (gotAddr.size() != expAddr.size()) begin
            $display("test %s: expected %0d peripheral writes but saw %0d",
                     name, expAddr.size(), gotAddr.size());
            errorCount++;
        end else begin
            for (int i = 0; i < expAddr.size(); i++) begin
                checkValue({name, " address"}, expAddr[i], gotAddr[i]);
                checkValue({name, " data"}, expData[i], gotData[i]);
            end
        end
        if (errorCount == errorsBefore) begin
            passCount++;
            $display("test %s: passed", name);
        end else begin
            failCount++;
            $display("test %s: failed", name);
        end
    endtask

    task automatic arithTest();
        wordT a;
        wordT b;
        wordT c;
        wordT d;
        a = -5;
        b = 1234;
        c = 'hf0f0;
        d = 'h1234_5678;
        startProgram();
        emit(iInstr(OP_ADDI, 1, 0, -5));
        emit(iInstr(OP_ADDIU, 2, 0, 1234));
        emit(iInstr(OP_ORI, 3, 0, 'hf0f0));    // zero-extended
        loadConst(4, d);
        emit(rInstr(FN_ADD, 5, 1, 4, 0));
        emit(rInstr(FN_SUBU, 6, 2, 4, 0));
        emit(rInstr(FN_AND, 7, 4, 3, 0));
        emit(rInstr(FN_OR, 8, 4, 3, 0));
        emit(rInstr(FN_XOR, 9, 4, 3, 0));
        emit(rInstr(FN_NOR, 10, 4, 3, 0));
        storeOut(1, a);
        storeOut(2, b);
        storeOut(3, c);
        storeOut(4, d);
        storeOut(5, d + a);
        storeOut(6, b - d);
        storeOut(7, d & c);
        storeOut(8, d | c);
        storeOut(9, d ^ c);
        storeOut(10, ~(d | c));
        endProgram();
        runProgram("arith");
    endtask

    task automatic shiftTest();
        wordT n;
        wordT p;
        n = 32'h8000_00f0;
        p = 7;
        startProgram();
        loadConst(1, n);
        emit(iInstr(OP_ADDI, 5, 0, 7));
        emit(rInstr(FN_SLL, 2, 0, 1, 4));
        emit(rInstr(FN_SRL, 3, 0, 1, 4));
        emit(rInstr(FN_SRA, 4, 0, 1, 4));
        emit(rInstr(FN_SLT, 6, 1, 5, 0));
        emit(rInstr(FN_SLTU, 7, 1, 5, 0));
        emit(rInstr(FN_SLT, 8, 5, 1, 0));
        emit(rInstr(FN_SLTU, 9, 5, 1, 0));
        emit(iInstr(OP_SLTI, 10, 1, 3));       // signed and unsigned disagree
        emit(iInstr(OP_SLTIU, 11, 5, -1));     // imm is all ones unsigned
        emit(iInstr(OP_SLTIU, 12, 1, 3));
        storeOut(2, n << 4);
        storeOut(3, n >> 4);
        storeOut(4, $signed(n) >>> 4);
        storeOut(6, wordT'($signed(n) < $signed(p)));
        storeOut(7, wordT'(n < p));
        storeOut(8, wordT'($signed(p) < $signed(n)));
        storeOut(9, wordT'(p < n));
        storeOut(10, wordT'($signed(n) < 3));
        storeOut(11, wordT'(p < 32'hffff_ffff));
        storeOut(12, wordT'(n < 32'd3));
        endProgram();
        runProgram("shift and compare");
    endtask

    task automatic memTest();
        wordT v1;
        wordT v2;
        wordT v3;
        v1 = 32'hdead_beef;
        v2 = 32'h0bad_f00d;
        v3 = 32'h1357_9bdf;
        startProgram();
        loadConst(1, v1);
        loadConst(2, v2);
        loadConst(3, v3);
        emit(iInstr(OP_SW, 1, 0, 'h100));
        emit(iInstr(OP_SW, 2, 0, 'h104));
        emit(iInstr(OP_SW, 3, 0, 'h3f8));
        emit(iInstr(OP_LW, 4, 0, 'h3f8));
        emit(iInstr(OP_LW, 5, 0, 'h100));
        emit(iInstr(OP_LW, 6, 0, 'h104));
        emit(iInstr(OP_ADDI, 0, 0, 99));       // dropped, r0 stays 0
        storeOut(4, v3);
        storeOut(5, v1);
        storeOut(6, v2);
        storeOut(0, 0);
        endProgram();
        runProgram("memory");
    endtask

    task automatic flowTest();
        int sub1;
        int sub2;
        int jalIdx;
        int jalrIdx;
        startProgram();
        emit(iInstr(OP_ADDI, 1, 0, 5));
        emit(iInstr(OP_ADDI, 2, 0, 5));
        emit(iInstr(OP_ADDI, 3, 0, 7));
        emit(iInstr(OP_BEQ, 2, 1, 1));         // taken
        badStore();
        storeOut(1, 5);
        emit(iInstr(OP_BEQ, 3, 1, 1));         // not taken
        storeOut(3, 7);
        emit(iInstr(OP_BNE, 3, 1, 1));         // taken
        badStore();
        emit(iInstr(OP_BNE, 2, 1, 1));         // not taken
        storeOut(2, 5);
        sub1 = prog.size() + 1;
        sub2 = sub1 + 2;
        emit(jInstr(OP_J, sub2 + 2));          // over both subroutines
        emit(iInstr(OP_ADDI, 10, 0, 'h11));
        emit(rInstr(FN_JR, 0, 31, 0, 0));
        emit(iInstr(OP_ADDI, 11, 0, 'h22));
        emit(rInstr(FN_JR, 0, 31, 0, 0));
        jalIdx = prog.size();
        emit(jInstr(OP_JAL, sub1));
        storeOut(31, addrOf(jalIdx + 1));
        loadConst(4, addrOf(sub2));
        jalrIdx = prog.size();
        emit(rInstr(FN_JALR, 31, 4, 0, 0));
        storeOut(31, addrOf(jalrIdx + 1));
        storeOut(10, 'h11);
        storeOut(11, 'h22);
        endProgram();
        runProgram("control flow");
    endtask

    task automatic illegalTest();
        int faultIdx;
        startProgram();
        emit(iInstr(OP_ADDI, 1, 0, 'h5a));
        storeOut(1, 'h5a);
        faultIdx = prog.size();
        emit(32'hfc00_0000);                   // opcode 0x3f is undefined
        badStore();
        expectWrite(PER_BASE + 'h800, addrOf(faultIdx + 1));  // handler stores r26
        runProgram("illegal instruction");
    endtask

    task automatic randomTest();
        wordT a;
        wordT b;
        startProgram();
        for (int k = 0; k < 4; k++) begin
            a = $random(seed);
            b = $random(seed);
            loadConst(1, a);
            loadConst(2, b);
            emit(rInstr(FN_ADD, 3, 1, 2, 0));
            emit(rInstr(FN_SUB, 4, 1, 2, 0));
            emit(rInstr(FN_XOR, 5, 1, 2, 0));
            emit(rInstr(FN_SLT, 6, 1, 2, 0));
            storeOut(3, a + b);
            storeOut(4, a - b);
            storeOut(5, a ^ b);
            storeOut(6, wordT'($signed(a) < $signed(b)));
        end
        endProgram();
        runProgram("random operands");
    endtask

    initial begin
        reset     = 1'b0;
        progWrite = 1'b0;
        progAddr  = '0;
        progData  = '0;
        arithTest();
        shiftTest();
        memTest();
        flowTest();
        illegalTest();
        randomTest();
        $display("tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0 && errorCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== monoCpu.f ====
+incdir+rtl
rtl/cpuPkg.sv
rtl/instrMem.sv
rtl/control.sv
rtl/regFile.sv
rtl/alu.sv
rtl/dataMem.sv
rtl/monoCpu.sv
test/monoCpu_sva.sv
test/monoCpuTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the monoCpu testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f monoCpu.f \
    --top-module monoCpuTb \
    -Mdir obj_dir -o monoCpuTbSim

./obj_dir/monoCpuTbSim | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    echo "run.sh: pass"
else
    echo "run.sh: fail, see sim.log"
    exit 1
fi
